//--- vic_load_pkg.sv
// Shared definitions for the loader path
// Width typedefs, host stream and write bus structs
// Download indices and memory-map constants

`default_nettype none

package vic_load_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] load_addr_t;
	typedef logic [24:0] ioctl_addr_t;
	// Bits 0-3 for blocks 0x0000-0x6000, bit 4 for 0xA000
	typedef logic [4:0]  cart_blk_t;

	// Byte stream from the host
	typedef struct packed {
		logic        download;
		byte_t       index;
		logic        wr;
		ioctl_addr_t addr;
		byte_t       dout;
		byte_t       file_ext;
	} host_dl_t;

	// One byte write on the configuration bus
	typedef struct packed {
		logic       valid;
		load_addr_t addr;
		byte_t      data;
	} conf_wr_t;

	////////////////////////////////////////////////////////////
	// Download indices and memory map
	////////////////////////////////////////////////////////////

	localparam byte_t IDX_PRG = 8'h01;
	localparam byte_t IDX_CRT = 8'h41;
	localparam byte_t IDX_CT  = 8'h81;
	localparam byte_t IDX_ROM = 8'h06;

	localparam load_addr_t  PRG_LIMIT  = 16'hA000;
	localparam load_addr_t  CART_LIMIT = 16'hC000;
	localparam ioctl_addr_t ROM_WIN_LO = 25'h0004000;
	localparam ioctl_addr_t ROM_WIN_HI = 25'h0008000;
	localparam load_addr_t  ROM_OFFSET = 16'h8000;

	// BASIC end-of-program pointers, low byte at even positions
	localparam load_addr_t [0:7] PTR_ADDR = {
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AE, 16'h00AF
	};

	localparam int NUM_LOADERS = 3;

endpackage

`default_nettype wire

//--- prg_loader.sv
// Program file loader
// Two-byte header sets the load address, payload lands below 0xA000
// End-pointer patch sequence runs after the download finishes

`timescale 1ns/1ns
`default_nettype none

module prg_loader
	import vic_load_pkg::*;
(
	input  wire           clk_sys,
	input  wire           reset,
	input  wire host_dl_t host_i,
	output conf_wr_t      req_o
);

	typedef enum logic [1:0] {
		PS_IDLE,
		PS_WRITE,
		PS_GAP
	} patch_state_t;

	patch_state_t state;
	logic [2:0]   ptr_idx;
	logic         dl_q;
	load_addr_t   run_addr;
	conf_wr_t     req_d;

	logic prg_active;
	logic prg_wr;
	logic is_hdr;
	logic dl_fall;

	assign prg_active = host_i.download && (host_i.index == IDX_PRG);
	assign prg_wr     = prg_active && host_i.wr;
	assign is_hdr     = (host_i.addr == 25'd0) || (host_i.addr == 25'd1);
	assign dl_fall    = dl_q && !host_i.download && (host_i.index == IDX_PRG);

	// Running load address
	always_ff @(posedge clk_sys) begin
		if (prg_wr) begin
			if (host_i.addr == 25'd0)
				run_addr[7:0] <= host_i.dout;
			else if (host_i.addr == 25'd1)
				run_addr[15:8] <= host_i.dout;
			else if (run_addr < PRG_LIMIT)
				run_addr <= run_addr + 16'd1;
		end
	end

	// Payload byte or one pointer byte per cycle
	always_comb begin
		req_d = '0;
		if (prg_wr && !is_hdr && (run_addr < PRG_LIMIT)) begin
			req_d.valid = 1'b1;
			req_d.addr  = run_addr;
			req_d.data  = host_i.dout;
		end else if ((state == PS_WRITE) && !prg_active) begin
			req_d.valid = 1'b1;
			req_d.addr  = PTR_ADDR[ptr_idx];
			req_d.data  = ptr_idx[0] ? run_addr[15:8] : run_addr[7:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Patch FSM, writes spaced two cycles apart
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= PS_IDLE;
			ptr_idx     <= 3'd0;
			dl_q        <= 1'b0;
			req_o.valid <= 1'b0;
		end else begin
			dl_q  <= host_i.download;
			req_o <= req_d;
			if (prg_active) begin
				// New program download aborts a running patch
				state <= PS_IDLE;
			end else begin
				case (state)
					PS_IDLE: begin
						if (dl_fall) begin
							state   <= PS_WRITE;
							ptr_idx <= 3'd0;
						end
					end
					PS_WRITE: state <= (ptr_idx == 3'd7) ? PS_IDLE : PS_GAP;
					PS_GAP: begin
						ptr_idx <= ptr_idx + 3'd1;
						state   <= PS_WRITE;
					end
					default: state <= PS_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- cart_loader.sv
// Cartridge loader
// Address from the CRT header or from the CT file extension
// Writes below 0xC000 and flags each 8 KB block it fills

`timescale 1ns/1ns
`default_nettype none

module cart_loader
	import vic_load_pkg::*;
(
	input  wire           clk_sys,
	input  wire           reset,
	input  wire host_dl_t host_i,
	output conf_wr_t      req_o,
	output cart_blk_t     cart_blk_o
);

	load_addr_t run_addr;
	load_addr_t ext_addr;
	cart_blk_t  blk_hit;
	conf_wr_t   req_d;
	logic       dl_q;
	logic       ext_hit;

	logic is_crt;
	logic is_ct;
	logic cart_wr;
	logic is_hdr;
	logic dl_rise;
	logic data_wr;

	assign is_crt  = host_i.index == IDX_CRT;
	assign is_ct   = host_i.index == IDX_CT;
	assign cart_wr = host_i.download && (is_crt || is_ct) && host_i.wr;
	assign is_hdr  = is_crt && ((host_i.addr == 25'd0) || (host_i.addr == 25'd1));
	assign dl_rise = !dl_q && host_i.download && is_ct;
	assign data_wr = cart_wr && !is_hdr && (run_addr < CART_LIMIT);

	// Start address from the last extension character, '2'-'9' or 'A'-'B'
	always_comb begin
		ext_hit  = 1'b1;
		ext_addr = '0;
		if ((host_i.file_ext >= "2") && (host_i.file_ext <= "9"))
			ext_addr = {host_i.file_ext[3:0], 12'h000};
		else if ((host_i.file_ext >= "A") && (host_i.file_ext <= "B"))
			ext_addr = {host_i.file_ext[3:0] + 4'd9, 12'h000};
		else
			ext_hit = 1'b0;
	end

	// Blocks 4 and 6 carry no flag
	always_comb begin
		blk_hit = '0;
		case (run_addr[15:13])
			3'd0: blk_hit[0] = 1'b1;
			3'd1: blk_hit[1] = 1'b1;
			3'd2: blk_hit[2] = 1'b1;
			3'd3: blk_hit[3] = 1'b1;
			3'd5: blk_hit[4] = 1'b1;
			default: blk_hit = '0;
		endcase
	end

	always_comb begin
		req_d.valid = data_wr;
		req_d.addr  = run_addr;
		req_d.data  = host_i.dout;
	end

	always_ff @(posedge clk_sys) begin
		if (dl_rise && ext_hit)
			run_addr <= ext_addr;
		else if (cart_wr && is_hdr && (host_i.addr == 25'd0))
			run_addr[7:0] <= host_i.dout;
		else if (cart_wr && is_hdr)
			run_addr[15:8] <= host_i.dout;
		else if (data_wr)
			run_addr <= run_addr + 16'd1;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q        <= 1'b0;
			req_o.valid <= 1'b0;
			cart_blk_o  <= '0;
		end else begin
			dl_q  <= host_i.download;
			req_o <= req_d;
			// Flags only accumulate until the next reset
			if (data_wr)
				cart_blk_o <= cart_blk_o | blk_hit;
		end
	end

endmodule

`default_nettype wire

//--- rom_loader.sv
// Kernal ROM loader
// File window 0x4000-0x7FFF written at offset plus 0x8000
// Standard-ROM select latched during reset

`timescale 1ns/1ns
`default_nettype none

module rom_loader
	import vic_load_pkg::*;
(
	input  wire           clk_sys,
	input  wire           reset,
	input  wire host_dl_t host_i,
	input  wire           rom_std_sel_i,
	output conf_wr_t      req_o,
	output logic          rom_std_o
);

	conf_wr_t req_d;
	logic     in_win;

	assign in_win = (host_i.addr >= ROM_WIN_LO) && (host_i.addr < ROM_WIN_HI);

	always_comb begin
		req_d.valid = host_i.download && (host_i.index == IDX_ROM) && host_i.wr && in_win;
		req_d.addr  = host_i.addr[15:0] + ROM_OFFSET;
		req_d.data  = host_i.dout;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			req_o.valid <= 1'b0;
		else
			req_o <= req_d;
	end

	// Select follows the input while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset)
			rom_std_o <= rom_std_sel_i;
	end

endmodule

`default_nettype wire

//--- conf_bus_arbiter.sv
// Fixed-priority arbiter for the configuration write bus
// Lowest port index wins, losers wait in a one-deep slot

`timescale 1ns/1ns
`default_nettype none

module conf_bus_arbiter
	import vic_load_pkg::*;
#(
	parameter int NUM_REQ = 3
)
(
	input  wire           clk_sys,
	input  wire           reset,
	input  wire conf_wr_t req_i [NUM_REQ],
	output conf_wr_t      conf_o
);

	conf_wr_t           slot_q [NUM_REQ];
	conf_wr_t           cand   [NUM_REQ];
	conf_wr_t           grant_wr;
	logic [NUM_REQ-1:0] gnt;

	// A pending item goes before a new request on the same port
	always_comb begin
		for (int i = 0; i < NUM_REQ; i++)
			cand[i] = slot_q[i].valid ? slot_q[i] : req_i[i];
	end

	////////////////////////////////////////////////////////////
	// Grant
	////////////////////////////////////////////////////////////

	always_comb begin
		logic taken;

		taken    = 1'b0;
		grant_wr = '0;
		for (int i = 0; i < NUM_REQ; i++) begin
			gnt[i] = cand[i].valid && !taken;
			if (gnt[i])
				grant_wr = cand[i];
			taken = taken || cand[i].valid;
		end
	end

	////////////////////////////////////////////////////////////
	// Output register and pending slots
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			conf_o.valid <= 1'b0;
			for (int i = 0; i < NUM_REQ; i++)
				slot_q[i].valid <= 1'b0;
		end else begin
			conf_o <= grant_wr;
			for (int i = 0; i < NUM_REQ; i++) begin
				if (gnt[i]) begin
					// Slot drained, a request arriving now takes its place
					slot_q[i] <= slot_q[i].valid ? req_i[i] : '0;
				end else begin
					slot_q[i] <= cand[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- vic_loader_top.sv
// Loader path top level
// Host stream fans out to the program, cartridge and kernal loaders
// Their requests share one write bus through the arbiter

`timescale 1ns/1ns
`default_nettype none

module vic_loader_top
	import vic_load_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset,
	input  wire host_dl_t  host_i,
	input  wire            rom_std_sel_i,
	output wire conf_wr_t  conf_o,
	output wire cart_blk_t cart_blk_o,
	output wire            rom_std_o
);

	// Port order sets the priority
	wire conf_wr_t ld_req [NUM_LOADERS];

	////////////////////////////////////////////////////////////
	// Loaders
	////////////////////////////////////////////////////////////

	prg_loader u_prg_loader (
		.clk_sys (clk_sys),
		.reset   (reset),
		.host_i  (host_i),
		.req_o   (ld_req[0])
	);

	cart_loader u_cart_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host_i     (host_i),
		.req_o      (ld_req[1]),
		.cart_blk_o (cart_blk_o)
	);

	rom_loader u_rom_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host_i        (host_i),
		.rom_std_sel_i (rom_std_sel_i),
		.req_o         (ld_req[2]),
		.rom_std_o     (rom_std_o)
	);

	////////////////////////////////////////////////////////////
	// Write bus
	////////////////////////////////////////////////////////////

	conf_bus_arbiter #(
		.NUM_REQ (NUM_LOADERS)
	) u_conf_bus_arbiter (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req_i   (ld_req),
		.conf_o  (conf_o)
	);

endmodule

`default_nettype wire

//--- tb_vic_loader_sva.sv
// Assertions for the write bus arbiter
// Slot overflow, output state after reset, uncontended latency

`timescale 1ns/1ns
`default_nettype none

module tb_vic_loader_sva
	import vic_load_pkg::*;
#(
	parameter int NUM_REQ = 3
)
(
	input wire           clk_sys,
	input wire           reset,
	input wire conf_wr_t req_i  [NUM_REQ],
	input wire conf_wr_t slot_q [NUM_REQ],
	input wire conf_wr_t conf_o
);

	// Port is uncontended when its slot and all higher-priority ports are empty
	logic [NUM_REQ-1:0] free_path;

	always_comb begin
		logic clear;

		clear = 1'b1;
		for (int i = 0; i < NUM_REQ; i++) begin
			free_path[i] = clear && !slot_q[i].valid;
			clear = clear && !slot_q[i].valid && !req_i[i].valid;
		end
	end

	a_reset_idle: assert property (@(posedge clk_sys) reset |=> !conf_o.valid)
		else $error("Write bus valid in the cycle after reset");

	for (genvar i = 0; i < NUM_REQ; i++) begin : g_port
		a_no_overflow: assert property (@(posedge clk_sys) disable iff (reset)
			req_i[i].valid |-> !slot_q[i].valid)
			else $error("Request on port %0d while its slot is full", i);

		a_direct: assert property (@(posedge clk_sys) disable iff (reset)
			req_i[i].valid && free_path[i] |=>
				conf_o.valid && (conf_o.addr == $past(req_i[i].addr)) &&
				(conf_o.data == $past(req_i[i].data)))
			else $error("Uncontended request on port %0d missing one cycle later", i);
	end

endmodule

bind conf_bus_arbiter tb_vic_loader_sva #(
	.NUM_REQ (NUM_REQ)
) u_sva (
	.clk_sys (clk_sys),
	.reset   (reset),
	.req_i   (req_i),
	.slot_q  (slot_q),
	.conf_o  (conf_o)
);

`default_nettype wire

//--- tb_vic_loader.sv
// Testbench for the loader path top level
// Download table applied in a loop with LFSR payload bytes
// Expected-write queues per loader, bus monitor and summary

`timescale 1ns/1ns
`default_nettype none

module tb_vic_loader
	import vic_load_pkg::*;
();

	// One download row
	// With chain set the next row starts before the bus drains
	typedef struct packed {
		byte_t       index;
		byte_t       ext;
		logic        has_hdr;
		load_addr_t  hdr;
		ioctl_addr_t first;
		int          count;
		logic        rom_sel;
		cart_blk_t   blk;
		logic        chain;
	} dl_row_t;

	localparam int NUM_ROWS    = 7;
	localparam int DRAIN_LIMIT = 200;

	logic        clk_sys;
	logic        reset;
	logic        rom_std_sel;
	host_dl_t    host;
	conf_wr_t    conf;
	cart_blk_t   cart_blk;
	logic        rom_std;
	dl_row_t     rows [NUM_ROWS];
	conf_wr_t    exp_q [NUM_LOADERS][$];
	logic [15:0] lfsr_state;
	int          err_val;
	int          err_other;

	vic_loader_top u_vic_loader_top (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host_i        (host),
		.rom_std_sel_i (rom_std_sel),
		.conf_o        (conf),
		.cart_blk_o    (cart_blk),
		.rom_std_o     (rom_std)
	);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	task automatic lfsr_byte(output byte_t b);
		b = '0;
		for (int k = 0; k < 8; k++) begin
			b = {lfsr_state[0], b[7:1]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp_v,
			input logic [31:0] got_v);
		if (got_v !== exp_v) begin
			err_val++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, got_v);
		end
	endtask

	task automatic push_exp(input int src, input load_addr_t a, input byte_t d);
		conf_wr_t w;

		w.valid = 1'b1;
		w.addr  = a;
		w.data  = d;
		exp_q[src].push_back(w);
	endtask

	function automatic int pending();
		return exp_q[0].size() + exp_q[1].size() + exp_q[2].size();
	endfunction

	// Host strobe every third cycle
	task automatic send_byte(input ioctl_addr_t a, input byte_t d);
		@(posedge clk_sys);
		host.wr   <= 1'b1;
		host.addr <= a;
		host.dout <= d;
		@(posedge clk_sys);
		host.wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic drain_wait();
		int n;

		n = 0;
		while ((pending() > 0) && (n < DRAIN_LIMIT)) begin
			@(posedge clk_sys);
			n++;
		end
		if (pending() > 0) begin
			err_other++;
			$display("Timeout at %0t ns: %0d expected writes never reached the bus",
				$time, pending());
			for (int k = 0; k < NUM_LOADERS; k++)
				exp_q[k].delete();
		end
	endtask

	////////////////////////////////////////////////////////////
	// One download with its expected writes
	////////////////////////////////////////////////////////////

	task automatic run_row(input dl_row_t r);
		load_addr_t  a;
		ioctl_addr_t base;
		ioctl_addr_t off;
		byte_t       d;
		byte_t       digit;

		base = r.first;
		a    = r.hdr;
		if (r.index == IDX_CT) begin
			digit = (r.ext >= "A") ? r.ext - "A" + 8'd10 : r.ext - "0";
			a     = {digit[3:0], 12'h000};
		end
		@(posedge clk_sys);
		host.index    <= r.index;
		host.file_ext <= r.ext;
		host.download <= 1'b1;
		rom_std_sel   <= r.rom_sel;
		if (r.has_hdr) begin
			send_byte(25'd0, r.hdr[7:0]);
			send_byte(25'd1, r.hdr[15:8]);
			base = base + 25'd2;
		end
		for (int i = 0; i < r.count; i++) begin
			lfsr_byte(d);
			off = base + ioctl_addr_t'(i);
			if (r.index == IDX_ROM) begin
				if ((off >= ROM_WIN_LO) && (off < ROM_WIN_HI))
					push_exp(2, off[15:0] + ROM_OFFSET, d);
			end else if (r.index == IDX_PRG) begin
				if (a < PRG_LIMIT) begin
					push_exp(0, a, d);
					a = a + 16'd1;
				end
			end else if (a < CART_LIMIT) begin
				push_exp(1, a, d);
				a = a + 16'd1;
			end
			send_byte(off, d);
		end
		@(posedge clk_sys);
		host.download <= 1'b0;
		// End pointers hold the final load address
		if (r.index == IDX_PRG)
			for (int k = 0; k < 8; k++)
				push_exp(0, PTR_ADDR[k], (k % 2 == 1) ? a[15:8] : a[7:0]);
		if (!r.chain) begin
			drain_wait();
			@(negedge clk_sys);
			check_value("cart_blk_o", 32'(r.blk), 32'(cart_blk));
			check_value("rom_std_o", 32'd1, 32'(rom_std));
		end
	endtask

	// Match each bus write to the head of one loader's queue
	always @(negedge clk_sys) begin
		int src;

		if (!reset && conf.valid) begin
			src = -1;
			for (int k = NUM_LOADERS - 1; k >= 0; k--)
				if ((exp_q[k].size() > 0) && (exp_q[k][0].addr == conf.addr))
					src = k;
			if (src < 0) begin
				err_other++;
				$display("Unexpected write of %h to address %h at %0t ns",
					conf.data, conf.addr, $time);
			end else begin
				check_value("conf_o.data", 32'(exp_q[src][0].data), 32'(conf.data));
				void'(exp_q[src].pop_front());
			end
		end
	end

	initial begin
		err_val     = 0;
		err_other   = 0;
		lfsr_state  = 16'd47222;
		reset       = 1'b1;
		rom_std_sel = 1'b1;
		host        = '0;
		rows[0] = '{IDX_PRG, "P", 1'b1, 16'h9FF0, 25'h0, 24, 1'b0, 5'b00000, 1'b0};
		rows[1] = '{IDX_CRT, "T", 1'b1, 16'h6000, 25'h0, 10240, 1'b0, 5'b01000, 1'b0};
		rows[2] = '{IDX_CT, "A", 1'b0, 16'h0000, 25'h0, 48, 1'b1, 5'b11000, 1'b0};
		rows[3] = '{IDX_CT, "3", 1'b0, 16'h0000, 25'h0, 48, 1'b0, 5'b11010, 1'b0};
		rows[4] = '{IDX_ROM, "M", 1'b0, 16'h0000, 25'h0, 'h8010, 1'b1, 5'b11010, 1'b0};
		rows[5] = '{IDX_PRG, "P", 1'b1, 16'h1000, 25'h0, 40, 1'b0, 5'b11010, 1'b1};
		// Kernal window bytes overlap the pointer patch of the row before
		rows[6] = '{IDX_ROM, "M", 1'b0, 16'h0000, 25'h4000, 16, 1'b0, 5'b11010, 1'b0};
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		// Quiet bus after reset
		repeat (20) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("cart_blk_o", 32'd0, 32'(cart_blk));
		check_value("rom_std_o", 32'd1, 32'(rom_std));
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(rows[r]);
		$display("Summary: %0d value errors, %0d other errors", err_val, err_other);
		if ((err_val + err_other) == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
vic_load_pkg.sv
prg_loader.sv
cart_loader.sv
rom_loader.sv
conf_bus_arbiter.sv
vic_loader_top.sv
tb_vic_loader_sva.sv
tb_vic_loader.sv
